/* source/fight_pkg.sv */
`default_nettype none

package fight_pkg;

  typedef enum logic [2:0] {
    state_idle      = 3'd0,
    state_countdown = 3'd1,
    state_fight     = 3'd2,
    state_p1_win    = 3'd3,
    state_p2_win    = 3'd4,
    state_draw      = 3'd5
  } game_state_t;

  // Pose codes in order
  // 0 idle, 1 walk, 2 walk back, 3 attack start, 4 attack end, 5 attack pull,
  // 6 dir attack start, 7 dir attack end, 8 dir attack pull, 9 got hit, 10 block
  // Codes 11 to 15 draw nothing
  typedef logic [3:0] pose_t;

  localparam int num_poses = 11;

  typedef logic [7:0] color_t;  // RRRGGGBB

  localparam color_t transparent_color = 8'b111_000_11;  // Magenta key
  localparam color_t heart_color       = 8'b111_000_00;
  localparam color_t shield_color      = 8'b000_000_11;
  localparam color_t digit_color       = 8'b111_111_11;
  localparam color_t background_color  = 8'b000_000_00;

  typedef logic [2:0] count3_t;  // Health or blocks, 3 and up all lit

  typedef logic player_t;  // 0 left, 1 right

endpackage

`default_nettype wire

/* source/screen_pkg.sv */
`default_nettype none

package screen_pkg;

  import fight_pkg::*;

  typedef logic [9:0] coord_t;

  localparam int screen_w = 640;
  localparam int screen_h = 480;

  localparam int icon_size   = 50;
  localparam int icon_margin = 40;
  localparam int icon_pitch  = 70;

  localparam int heart_row_y  = icon_margin;                          // 40
  localparam int shield_row_y = screen_h - icon_margin - icon_size;   // 390

  localparam int icon_bytes  = (icon_size * icon_size + 7) / 8;
  localparam int icon_addr_w = $clog2(icon_bytes);

  localparam int digit_w = 10;
  localparam int digit_h = 13;
  localparam int digit_x = screen_w / 2 - digit_w / 2;  // 315
  localparam int digit_y = screen_h / 2 - digit_h / 2;  // 234

  // Digits 1, 2, 3 stored back to back
  localparam int digit_bytes     = (digit_w * digit_h + 7) / 8;
  localparam int digit_rom_depth = 3 * digit_bytes;
  localparam int digit_addr_w    = $clog2(digit_rom_depth);

  typedef logic [7:0] bitmap_byte_t;  // MSB is first pixel

  typedef enum logic [2:0] {
    art_fighter1,
    art_fighter2,
    art_heart,
    art_shield,
    art_digit
  } art_t;

  // Left edge of icon n, counted from the outer screen edge
  function automatic coord_t icon_x(player_t player, int n);
    if (player)
      return coord_t'(screen_w - icon_margin - icon_size - n * icon_pitch);
    return coord_t'(icon_margin + n * icon_pitch);
  endfunction

  function automatic color_t sprite_texel(player_t player, pose_t pose, int col, int row);
    logic [1:0] blue;
    blue = 2'(pose[0]) + 2'(player);
    if ((col + row) % 4 == 0)
      return transparent_color;
    return {3'(col), 3'(row), blue};  // Blue never reaches 3 so never the key
  endfunction

  function automatic logic heart_bit(int col, int row);
    return ((col / 5 + row / 5) % 2) == 0;
  endfunction

  function automatic logic shield_bit(int col, int row);
    return col >= row;
  endfunction

  function automatic logic digit_bit(int d, int col, int row);
    return row == 0 || row == 6 || row == 12 || col == 9 ||
           (d == 3 && col == 0 && row == 6);
  endfunction

  function automatic logic [7:0] rom_word(art_t art, int addr, int spr_w, int spr_h);
    logic [7:0] word;
    int area;
    int lin;
    int col;
    int row;
    word = '0;
    area = spr_w * spr_h;
    case (art)
      art_fighter1, art_fighter2: begin
        col  = (addr % area) % spr_w;
        row  = (addr % area) / spr_w;
        word = sprite_texel(player_t'(art == art_fighter2), pose_t'(addr / area), col, row);
      end
      art_heart, art_shield: begin
        for (int b = 0; b < 8; b++) begin
          lin = addr * 8 + b;
          col = lin % icon_size;
          row = lin / icon_size;
          if (lin < icon_size * icon_size)
            word[7-b] = (art == art_heart) ? heart_bit(col, row) : shield_bit(col, row);
        end
      end
      default: begin
        for (int b = 0; b < 8; b++) begin
          lin = (addr % digit_bytes) * 8 + b;
          col = lin % digit_w;
          row = lin / digit_w;
          if (lin < digit_w * digit_h)
            word[7-b] = digit_bit(addr / digit_bytes + 1, col, row);
        end
      end
    endcase
    return word;
  endfunction

endpackage

`default_nettype wire

/* source/sprite_locator.sv */
`default_nettype none

module sprite_locator
  import fight_pkg::*;
  import screen_pkg::*;
#(
  parameter int  sprite_w = 113,
  parameter int  sprite_h = 157,
  localparam int area     = sprite_w * sprite_h,
  localparam int addr_w   = $clog2(num_poses * area)
) (
  input  logic              clk,
  input  logic              arst_n,
  input  coord_t            pixel_x,
  input  coord_t            pixel_y,
  input  coord_t            pos_x,
  input  coord_t            pos_y,
  input  pose_t             pose,
  output logic              hit,
  output logic [addr_w-1:0] rom_addr
);

  coord_t            rel_x;
  coord_t            rel_y;
  logic              in_box;
  logic [addr_w-1:0] addr_next;

  // Left or above the sprite wraps to a large offset
  assign rel_x = pixel_x - pos_x;
  assign rel_y = pixel_y - pos_y;

  assign in_box = rel_x < sprite_w && rel_y < sprite_h && pose < num_poses;

  assign addr_next = addr_w'(pose * area + rel_y * sprite_w + rel_x);  // Pose block then raster

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      hit <= 1'b0;
    else
      hit <= in_box;
  end

  always_ff @(posedge clk) begin
    rom_addr <= in_box ? addr_next : '0;  // Keep ROM in range off sprite
  end

endmodule

`default_nettype wire

/* source/hud_locator.sv */
`default_nettype none

module hud_locator
  import fight_pkg::*;
  import screen_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  coord_t                  pixel_x,
  input  coord_t                  pixel_y,
  input  count3_t                 p1_health,
  input  count3_t                 p2_health,
  input  count3_t                 p1_blocks,
  input  count3_t                 p2_blocks,
  input  game_state_t             game_state,
  input  logic [6:0]              game_duration,
  output logic                    heart_hit,
  output logic                    shield_hit,
  output logic                    digit_hit,
  output logic [icon_addr_w-1:0]  heart_addr,
  output logic [icon_addr_w-1:0]  shield_addr,
  output logic [digit_addr_w-1:0] digit_addr,
  output logic [2:0]              heart_bit_sel,
  output logic [2:0]              shield_bit_sel,
  output logic [2:0]              digit_bit_sel,
  output game_state_t             state_q,
  output logic                    digit_valid
);

  typedef struct packed {
    logic       hit;
    logic [5:0] col;
    logic [5:0] row;
  } icon_loc_t;

  // Icon n of a player is lit once its count exceeds n
  function automatic icon_loc_t locate_icon(coord_t x, coord_t y, int row_y,
                                            count3_t left_cnt, count3_t right_cnt);
    icon_loc_t loc;
    coord_t    dx;
    coord_t    dy;
    loc = '0;
    dy  = y - coord_t'(row_y);
    for (int n = 0; n < 3; n++) begin
      dx = x - icon_x(1'b0, n);
      if (dx < icon_size && dy < icon_size && left_cnt > n) begin
        loc = {1'b1, dx[5:0], dy[5:0]};
      end
      dx = x - icon_x(1'b1, n);
      if (dx < icon_size && dy < icon_size && right_cnt > n) begin
        loc = {1'b1, dx[5:0], dy[5:0]};
      end
    end
    return loc;
  endfunction

  icon_loc_t                heart_loc;
  icon_loc_t                shield_loc;
  logic [11:0]              heart_lin;
  logic [11:0]              shield_lin;
  coord_t                   digit_dx;
  coord_t                   digit_dy;
  logic [7:0]               digit_lin;
  logic                     digit_in_box;
  logic                     duration_ok;
  logic [1:0]               digit_slot;
  logic [digit_addr_w-1:0]  digit_addr_next;

  assign heart_loc  = locate_icon(pixel_x, pixel_y, heart_row_y, p1_health, p2_health);
  assign shield_loc = locate_icon(pixel_x, pixel_y, shield_row_y, p1_blocks, p2_blocks);

  assign heart_lin  = 12'(heart_loc.row * icon_size + heart_loc.col);
  assign shield_lin = 12'(shield_loc.row * icon_size + shield_loc.col);

  assign digit_dx     = pixel_x - coord_t'(digit_x);
  assign digit_dy     = pixel_y - coord_t'(digit_y);
  assign digit_in_box = digit_dx < digit_w && digit_dy < digit_h;
  assign digit_lin    = digit_in_box ? 8'(digit_dy * digit_w + digit_dx) : 8'd0;

  // Duration 1, 2, 3 shows digit 3, 2, 1
  assign duration_ok     = game_duration >= 7'd1 && game_duration <= 7'd3;
  assign digit_slot      = duration_ok ? 2'(7'd3 - game_duration) : 2'd0;
  assign digit_addr_next = digit_addr_w'(digit_slot * digit_bytes + (digit_lin >> 3));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      heart_hit   <= 1'b0;
      shield_hit  <= 1'b0;
      digit_hit   <= 1'b0;
      digit_valid <= 1'b0;
      state_q     <= state_idle;
    end else begin
      heart_hit   <= heart_loc.hit;
      shield_hit  <= shield_loc.hit;
      digit_hit   <= digit_in_box;
      digit_valid <= duration_ok;
      state_q     <= game_state;
    end
  end

  always_ff @(posedge clk) begin
    heart_addr     <= heart_lin[icon_addr_w+2:3];
    shield_addr    <= shield_lin[icon_addr_w+2:3];
    digit_addr     <= digit_addr_next;
    heart_bit_sel  <= heart_lin[2:0];
    shield_bit_sel <= shield_lin[2:0];
    digit_bit_sel  <= digit_lin[2:0];
  end

endmodule

`default_nettype wire

/* source/pixel_rom.sv */
`default_nettype none

module pixel_rom
  import screen_pkg::*;
#(
  parameter type  word_t   = logic [7:0],
  parameter int   depth    = 256,
  parameter art_t art      = art_heart,
  parameter int   sprite_w = 1,   // Only fighter art reads these
  parameter int   sprite_h = 1
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] addr,
  output word_t                    data
);

  word_t mem [depth];

  // Contents come from the package art so the model can predict them
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = word_t'(rom_word(art, i, sprite_w, sprite_h));
    end
  end

  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

`default_nettype wire

/* source/pixel_compose.sv */
`default_nettype none

module pixel_compose
  import fight_pkg::*;
  import screen_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         p1_hit,
  input  logic         p2_hit,
  input  logic         heart_hit,
  input  logic         shield_hit,
  input  logic         digit_hit,
  input  logic [2:0]   heart_bit_sel,
  input  logic [2:0]   shield_bit_sel,
  input  logic [2:0]   digit_bit_sel,
  input  game_state_t  state_q,
  input  logic         digit_valid,
  input  color_t       p1_texel,
  input  color_t       p2_texel,
  input  bitmap_byte_t heart_word,
  input  bitmap_byte_t shield_word,
  input  bitmap_byte_t digit_word,
  output color_t       pixel_data
);

  logic        p1_hit_d;
  logic        p2_hit_d;
  logic        heart_hit_d;
  logic        shield_hit_d;
  logic        digit_hit_d;
  logic        digit_valid_d;
  game_state_t state_d;
  logic [2:0]  heart_sel_d;
  logic [2:0]  shield_sel_d;
  logic [2:0]  digit_sel_d;
  color_t      color_next;

  // Flags wait one cycle alongside the ROM read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p1_hit_d      <= 1'b0;
      p2_hit_d      <= 1'b0;
      heart_hit_d   <= 1'b0;
      shield_hit_d  <= 1'b0;
      digit_hit_d   <= 1'b0;
      digit_valid_d <= 1'b0;
      state_d       <= state_idle;
    end else begin
      p1_hit_d      <= p1_hit;
      p2_hit_d      <= p2_hit;
      heart_hit_d   <= heart_hit;
      shield_hit_d  <= shield_hit;
      digit_hit_d   <= digit_hit;
      digit_valid_d <= digit_valid;
      state_d       <= state_q;
    end
  end

  always_ff @(posedge clk) begin
    heart_sel_d  <= heart_bit_sel;
    shield_sel_d <= shield_bit_sel;
    digit_sel_d  <= digit_bit_sel;
  end

  always_comb begin
    color_next = background_color;
    case (state_d)
      state_countdown: begin
        if (digit_hit_d && digit_valid_d && digit_word[3'd7 - digit_sel_d])
          color_next = digit_color;
      end
      state_fight: begin
        if (heart_hit_d)
          color_next = heart_word[3'd7 - heart_sel_d] ? heart_color : transparent_color;
        else if (shield_hit_d)
          color_next = shield_word[3'd7 - shield_sel_d] ? shield_color : transparent_color;
        else if (p1_hit_d && p1_texel != transparent_color)
          color_next = p1_texel;  // Left fighter in front
        else if (p2_hit_d)
          color_next = p2_texel;
        else
          color_next = transparent_color;
      end
      default: color_next = background_color;  // Idle and end screens
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      pixel_data <= background_color;
    else
      pixel_data <= color_next;
  end

endmodule

`default_nettype wire

/* source/frame_renderer.sv */
`default_nettype none

module frame_renderer
  import fight_pkg::*;
  import screen_pkg::*;
#(
  parameter int sprite_w = 113,
  parameter int sprite_h = 157
) (
  input  logic        clk,
  input  logic        arst_n,
  input  coord_t      pixel_x,
  input  coord_t      pixel_y,
  input  coord_t      p1_x,
  input  coord_t      p1_y,
  input  coord_t      p2_x,
  input  coord_t      p2_y,
  input  pose_t       p1_pose,
  input  pose_t       p2_pose,
  input  count3_t     p1_health,
  input  count3_t     p2_health,
  input  count3_t     p1_blocks,
  input  count3_t     p2_blocks,
  input  game_state_t game_state,
  input  logic [6:0]  game_duration,
  output color_t      pixel_data
);

  localparam int sprite_depth  = num_poses * sprite_w * sprite_h;  // All poses of one fighter
  localparam int sprite_addr_w = $clog2(sprite_depth);

  logic                     p1_hit;
  logic                     p2_hit;
  logic [sprite_addr_w-1:0] p1_addr;
  logic [sprite_addr_w-1:0] p2_addr;
  color_t                   p1_texel;
  color_t                   p2_texel;
  logic                     heart_hit;
  logic                     shield_hit;
  logic                     digit_hit;
  logic [icon_addr_w-1:0]   heart_addr;
  logic [icon_addr_w-1:0]   shield_addr;
  logic [digit_addr_w-1:0]  digit_addr;
  logic [2:0]               heart_bit_sel;
  logic [2:0]               shield_bit_sel;
  logic [2:0]               digit_bit_sel;
  game_state_t              state_q;
  logic                     digit_valid;
  bitmap_byte_t             heart_word;
  bitmap_byte_t             shield_word;
  bitmap_byte_t             digit_word;

  sprite_locator #(.sprite_w(sprite_w), .sprite_h(sprite_h)) u_p1_locator (
    .clk(clk), .arst_n(arst_n), .pixel_x(pixel_x), .pixel_y(pixel_y),
    .pos_x(p1_x), .pos_y(p1_y), .pose(p1_pose), .hit(p1_hit), .rom_addr(p1_addr)
  );

  sprite_locator #(.sprite_w(sprite_w), .sprite_h(sprite_h)) u_p2_locator (
    .clk(clk), .arst_n(arst_n), .pixel_x(pixel_x), .pixel_y(pixel_y),
    .pos_x(p2_x), .pos_y(p2_y), .pose(p2_pose), .hit(p2_hit), .rom_addr(p2_addr)
  );

  hud_locator u_hud_locator (
    .clk(clk), .arst_n(arst_n), .pixel_x(pixel_x), .pixel_y(pixel_y),
    .p1_health(p1_health), .p2_health(p2_health),
    .p1_blocks(p1_blocks), .p2_blocks(p2_blocks),
    .game_state(game_state), .game_duration(game_duration),
    .heart_hit(heart_hit), .shield_hit(shield_hit), .digit_hit(digit_hit),
    .heart_addr(heart_addr), .shield_addr(shield_addr), .digit_addr(digit_addr),
    .heart_bit_sel(heart_bit_sel), .shield_bit_sel(shield_bit_sel),
    .digit_bit_sel(digit_bit_sel), .state_q(state_q), .digit_valid(digit_valid)
  );

  pixel_rom #(
    .word_t(color_t), .depth(sprite_depth), .art(art_fighter1),
    .sprite_w(sprite_w), .sprite_h(sprite_h)
  ) u_p1_rom (.clk(clk), .addr(p1_addr), .data(p1_texel));

  pixel_rom #(
    .word_t(color_t), .depth(sprite_depth), .art(art_fighter2),
    .sprite_w(sprite_w), .sprite_h(sprite_h)
  ) u_p2_rom (.clk(clk), .addr(p2_addr), .data(p2_texel));

  pixel_rom #(.word_t(bitmap_byte_t), .depth(icon_bytes), .art(art_heart)) u_heart_rom (
    .clk(clk), .addr(heart_addr), .data(heart_word)
  );

  pixel_rom #(.word_t(bitmap_byte_t), .depth(icon_bytes), .art(art_shield)) u_shield_rom (
    .clk(clk), .addr(shield_addr), .data(shield_word)
  );

  pixel_rom #(.word_t(bitmap_byte_t), .depth(digit_rom_depth), .art(art_digit)) u_digit_rom (
    .clk(clk), .addr(digit_addr), .data(digit_word)
  );

  pixel_compose u_compose (
    .clk(clk), .arst_n(arst_n), .p1_hit(p1_hit), .p2_hit(p2_hit),
    .heart_hit(heart_hit), .shield_hit(shield_hit), .digit_hit(digit_hit),
    .heart_bit_sel(heart_bit_sel), .shield_bit_sel(shield_bit_sel),
    .digit_bit_sel(digit_bit_sel), .state_q(state_q), .digit_valid(digit_valid),
    .p1_texel(p1_texel), .p2_texel(p2_texel), .heart_word(heart_word),
    .shield_word(shield_word), .digit_word(digit_word), .pixel_data(pixel_data)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int period = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period / 2) clk = ~clk;  // Free running

endmodule

`default_nettype wire

/* sim/frame_renderer_chk.sv */
`default_nettype none

module frame_renderer_chk
  import fight_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input game_state_t game_state,
  input color_t      pixel_data
);

  int fail_count = 0;  // Read by the testbench at the end

  // Output registered two edges after sampling is seen on the third
  a_known : assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(pixel_data))
    else begin
      $error("pixel_data is unknown");
      fail_count++;
    end

  a_idle_black : assert property (@(posedge clk) disable iff (!arst_n)
    game_state == state_idle |-> ##3 pixel_data == background_color)
    else begin
      $error("pixel_data not black three cycles after idle state");
      fail_count++;
    end

  a_countdown_opaque : assert property (@(posedge clk) disable iff (!arst_n)
    game_state == state_countdown |-> ##3 pixel_data != transparent_color)
    else begin
      $error("transparent colour three cycles after countdown state");
      fail_count++;
    end

endmodule

bind frame_renderer frame_renderer_chk u_chk (
  .clk(clk), .arst_n(arst_n), .game_state(game_state), .pixel_data(pixel_data)
);

`default_nettype wire

/* sim/frame_renderer_tb.sv */
`default_nettype none

module frame_renderer_tb
  import fight_pkg::*;
  import screen_pkg::*;
();

  localparam int sprite_w      = 32;
  localparam int sprite_h      = 40;
  localparam int clk_period    = 40;
  localparam int latency       = 3;
  localparam int reset_cycles  = 8;
  localparam int idle_len      = 300;
  localparam int countdown_len = 600;
  localparam int icon_len      = 800;
  localparam int fighter_len   = 1000;
  localparam int mixed_len     = 1500;
  localparam int total_cycles  = reset_cycles + idle_len + countdown_len + icon_len +
                                 fighter_len + mixed_len + 5 * (latency + 1);

  typedef struct packed {
    color_t exp;
    coord_t x;
    coord_t y;
  } expect_t;

  logic        clk;
  logic        arst_n;
  coord_t      pixel_x;
  coord_t      pixel_y;
  coord_t      p1_x;
  coord_t      p1_y;
  coord_t      p2_x;
  coord_t      p2_y;
  pose_t       p1_pose;
  pose_t       p2_pose;
  count3_t     p1_health;
  count3_t     p2_health;
  count3_t     p1_blocks;
  count3_t     p2_blocks;
  game_state_t game_state;
  logic [6:0]  game_duration;
  color_t      pixel_data;

  expect_t expect_q[$];  // Pixels in flight
  expect_t pending;      // Pixel held on the inputs
  integer  seed   = 32'hcf77_3ea3;
  int      errors = 0;
  int      checks = 0;

  tb_clock #(.period(clk_period)) u_clock (.clk(clk));

  frame_renderer #(.sprite_w(sprite_w), .sprite_h(sprite_h)) u_dut (
    .clk(clk), .arst_n(arst_n), .pixel_x(pixel_x), .pixel_y(pixel_y),
    .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
    .p1_pose(p1_pose), .p2_pose(p2_pose), .p1_health(p1_health), .p2_health(p2_health),
    .p1_blocks(p1_blocks), .p2_blocks(p2_blocks), .game_state(game_state),
    .game_duration(game_duration), .pixel_data(pixel_data)
  );

  function automatic int rand_range(int lo, int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic coord_t clamp_coord(int v, int hi);
    return coord_t'(v < 0 ? 0 : (v > hi ? hi : v));
  endfunction

  // Icon n of a row lights once the count reaches n
  function automatic logic icon_lookup(int x, int y, int row_y, int left_cnt, int right_cnt,
                                       logic is_heart, output color_t color);
    int   x0;
    int   cnt;
    logic on;
    color = background_color;
    for (int n = 1; n <= 3; n++) begin
      for (int p = 0; p < 2; p++) begin
        x0  = (p == 0) ? icon_margin + (n - 1) * icon_pitch
                       : screen_w - icon_margin - icon_size - (n - 1) * icon_pitch;
        cnt = (p == 0) ? left_cnt : right_cnt;
        if (cnt >= n && x >= x0 && x < x0 + icon_size && y >= row_y && y < row_y + icon_size) begin
          on    = is_heart ? heart_bit(x - x0, y - row_y) : shield_bit(x - x0, y - row_y);
          color = !on ? transparent_color : (is_heart ? heart_color : shield_color);
          return 1'b1;
        end
      end
    end
    return 1'b0;
  endfunction

  function automatic logic sprite_lookup(player_t player, int x, int y, int px, int py,
                                         pose_t pose, output color_t texel);
    texel = transparent_color;
    if (pose > 4'd10 || x < px || x >= px + sprite_w || y < py || y >= py + sprite_h)
      return 1'b0;  // Off the sprite or invalid pose
    texel = sprite_texel(player, pose, x - px, y - py);
    return 1'b1;
  endfunction

  function automatic color_t expected_color();
    color_t color;
    color_t t1;
    color_t t2;
    logic   on1;
    logic   on2;
    int     x;
    int     y;
    x = pixel_x;
    y = pixel_y;
    if (game_state == state_countdown) begin
      if (game_duration >= 7'd1 && game_duration <= 7'd3 &&
          x >= digit_x && x < digit_x + digit_w && y >= digit_y && y < digit_y + digit_h &&
          digit_bit(4 - int'(game_duration), x - digit_x, y - digit_y))
        return digit_color;
      return background_color;
    end
    if (game_state != state_fight)
      return background_color;  // Idle and end screens
    if (icon_lookup(x, y, heart_row_y, p1_health, p2_health, 1'b1, color))
      return color;
    if (icon_lookup(x, y, shield_row_y, p1_blocks, p2_blocks, 1'b0, color))
      return color;
    on1 = sprite_lookup(1'b0, x, y, p1_x, p1_y, p1_pose, t1);
    on2 = sprite_lookup(1'b1, x, y, p2_x, p2_y, p2_pose, t2);
    if (on1 && t1 != transparent_color)
      return t1;
    if (on2)
      return t2;
    return transparent_color;
  endfunction

  task automatic check_color(input color_t got, input color_t exp, input coord_t x,
                             input coord_t y);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch pixel_data at x %0d y %0d: got %h expected %h", x, y, got, exp);
    end
  endtask

  // Pixel sampled two edges back is on the output now
  task automatic next_cycle();
    expect_t item;
    @(posedge clk);
    #1;
    expect_q.push_back(pending);
    if (expect_q.size() == latency) begin
      item = expect_q.pop_front();
      check_color(pixel_data, item.exp, item.x, item.y);
    end
    #1;
  endtask

  task automatic latch_expected();
    pending.exp = expected_color();
    pending.x   = pixel_x;
    pending.y   = pixel_y;
  endtask

  // Kind 0 digit box, 1 icon rows, 2 and 3 sprite boxes, else anywhere
  task automatic pick_pixel(input int kind);
    int x;
    int y;
    x = rand_range(0, screen_w - 1);
    y = rand_range(0, screen_h - 1);
    case (kind)
      0: begin
        x = rand_range(digit_x - 3, digit_x + digit_w + 2);
        y = rand_range(digit_y - 3, digit_y + digit_h + 2);
      end
      1: y = (rand_range(0, 1) ? heart_row_y : shield_row_y) + rand_range(-3, icon_size + 2);
      2: begin
        x = int'(p1_x) + rand_range(-3, sprite_w + 2);
        y = int'(p1_y) + rand_range(-3, sprite_h + 2);
      end
      3: begin
        x = int'(p2_x) + rand_range(-3, sprite_w + 2);
        y = int'(p2_y) + rand_range(-3, sprite_h + 2);
      end
      default: ;
    endcase
    pixel_x = clamp_coord(x, screen_w - 1);
    pixel_y = clamp_coord(y, screen_h - 1);
  endtask

  task automatic pick_fighters();
    p1_x    = coord_t'(rand_range(0, screen_w - sprite_w));
    p1_y    = coord_t'(rand_range(0, screen_h - sprite_h));
    p2_x    = clamp_coord(int'(p1_x) + rand_range(-24, 24), screen_w - sprite_w);  // Overlap
    p2_y    = clamp_coord(int'(p1_y) + rand_range(-24, 24), screen_h - sprite_h);
    p1_pose = pose_t'(rand_range(0, 15));
    p2_pose = pose_t'(rand_range(0, 15));
  endtask

  task automatic randomize_inputs(input int mode);
    pick_fighters();
    p1_health     = count3_t'(rand_range(0, 7));
    p2_health     = count3_t'(rand_range(0, 7));
    p1_blocks     = count3_t'(rand_range(0, 7));
    p2_blocks     = count3_t'(rand_range(0, 7));
    game_duration = 7'(rand_range(0, 7) == 0 ? rand_range(4, 127) : rand_range(0, 3));
    case (mode)
      0: game_state = state_idle;
      1: game_state = state_countdown;
      2, 3: game_state = state_fight;
      default: game_state = game_state_t'(rand_range(0, 5));
    endcase
    case (mode)
      1: pick_pixel(rand_range(0, 3) == 0 ? 4 : 0);
      2: pick_pixel(rand_range(0, 3) == 0 ? rand_range(2, 4) : 1);
      3: pick_pixel(rand_range(2, 3));
      default: pick_pixel(rand_range(0, 4));
    endcase
  endtask

  task automatic run_test(input string name, input int cycles, input int mode);
    int mark;
    mark = errors;
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      randomize_inputs(mode);
      latch_expected();
    end
    for (int i = 0; i <= latency; i++) begin
      next_cycle();  // Drain the last pixels
    end
    $display("Test %-10s %0d cycles, %0d errors", name, cycles, errors - mark);
  endtask

  initial begin
    arst_n        = 1'b0;
    pixel_x       = '0;
    pixel_y       = '0;
    p1_x          = '0;
    p1_y          = '0;
    p2_x          = '0;
    p2_y          = '0;
    p1_pose       = '0;
    p2_pose       = '0;
    p1_health     = '0;
    p2_health     = '0;
    p1_blocks     = '0;
    p2_blocks     = '0;
    game_state    = state_idle;
    game_duration = '0;
    latch_expected();
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      #1;
      check_color(pixel_data, background_color, pixel_x, pixel_y);
      #1;
    end
    arst_n = 1'b1;
    $display("Test %-10s %0d cycles, %0d errors", "reset", reset_cycles, errors);
    run_test("idle", idle_len, 0);
    run_test("countdown", countdown_len, 1);
    run_test("icons", icon_len, 2);
    run_test("fighters", fighter_len, 3);
    run_test("pipeline", mixed_len, 4);
    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, u_dut.u_chk.fail_count);
    if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((total_cycles + 100) * clk_period);
    $display("Timeout: the run did not end within %0d cycles", total_cycles + 100);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* frame_renderer.f */
source/fight_pkg.sv
source/screen_pkg.sv
source/sprite_locator.sv
source/hud_locator.sv
source/pixel_rom.sv
source/pixel_compose.sv
source/frame_renderer.sv
sim/tb_clock.sv
sim/frame_renderer_chk.sv
sim/frame_renderer_tb.sv
